// ==== Bender.yml ====
package:
  name: gfx

sources:
  - gfx_cfg_pkg.sv
  - vram_fmt_pkg.sv
  - tile_job_if.sv
  - tile_fetcher.sv
  - tile_renderer.sv
  - line_buffer.sv
  - gfx.sv
  - target: test
    files:
      - tb_vram.sv
      - tb_gfx.sv

// ==== flist.f ====
gfx_cfg_pkg.sv
vram_fmt_pkg.sv
tile_job_if.sv
tile_fetcher.sv
tile_renderer.sv
line_buffer.sv
gfx.sv
tb_vram.sv
tb_gfx.sv

// ==== gfx.sv ====
`timescale 1ns/1ps

module gfx #(
    parameter int CREDITS = 2
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,

    // Line parameters
    input  logic              [7:0] vline,
    input  logic              [8:0] scrx,
    input  logic              [7:0] scry,

    // Video RAM port
    output logic             [12:0] vaddr,
    input  logic             [15:0] vdata,

    // Display side of the line buffer
    input  gfx_cfg_pkg::pixel_idx_t linebuf_rdidx,
    output gfx_cfg_pkg::pixel_t     linebuf_data,

    output logic                    busy,
    output logic                    line_done
);
    import gfx_cfg_pkg::*;

    pixel_idx_t wr_idx;
    pixel_t     wr_pixel;
    logic       wr_en;

    tile_job_if #(.CREDITS(CREDITS)) jobs_if (
        .clk   (clk),
        .reset (reset)
    );

    ////////////////////////////////////////////////////////////
    // Fetch, draw and store
    ////////////////////////////////////////////////////////////
    tile_fetcher #(.CREDITS(CREDITS)) u_fetcher (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .vline (vline),
        .scrx  (scrx[8:3]),
        .scry  (scry),
        .vaddr (vaddr),
        .vdata (vdata),
        .jobs  (jobs_if.source),
        .busy  (busy)
    );

    tile_renderer #(.CREDITS(CREDITS)) u_renderer (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .scrx_fine (scrx[2:0]),
        .jobs      (jobs_if.sink),
        .wr_idx    (wr_idx),
        .wr_pixel  (wr_pixel),
        .wr_en     (wr_en),
        .line_done (line_done)
    );

    // Banks swap on the same edge that starts a new line
    line_buffer u_linebuf (
        .clk      (clk),
        .reset    (reset),
        .swap     (start),
        .wr_idx   (wr_idx),
        .wr_pixel (wr_pixel),
        .wr_en    (wr_en),
        .rd_idx   (linebuf_rdidx),
        .rd_pixel (linebuf_data)
    );

endmodule

// ==== gfx_cfg_pkg.sv ====
package gfx_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // Screen geometry
    ////////////////////////////////////////////////////////////

    // Visible background pixels on one scan line
    localparam int LINE_PIXELS = 320;

    // One tile beyond the visible 40 so that fine scroll has pixels to show
    localparam int TILES_PER_LINE = 41;

    // Display line that maps to background line zero
    localparam int TOP_BORDER = 16;

    // Pixel position within a line
    typedef logic [8:0] pixel_idx_t;

    // Line buffer entry
    typedef struct packed {
        logic [1:0] palette;
        logic [3:0] color;
    } pixel_t;

endpackage

// ==== line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    swap,
    input  gfx_cfg_pkg::pixel_idx_t wr_idx,
    input  gfx_cfg_pkg::pixel_t     wr_pixel,
    input  logic                    wr_en,
    input  gfx_cfg_pkg::pixel_idx_t rd_idx,
    output gfx_cfg_pkg::pixel_t     rd_pixel
);
    import gfx_cfg_pkg::*;

    localparam pixel_idx_t LAST_IDX = 9'(LINE_PIXELS - 1);

    pixel_t bank0 [LINE_PIXELS];
    pixel_t bank1 [LINE_PIXELS];

    logic       sel_r;
    logic       clearing_r;
    pixel_idx_t clr_idx_r;

    pixel_idx_t waddr;
    pixel_t     wdata;
    logic       we0;
    logic       we1;

    // Clear pass owns both write ports until every entry is zero
    assign waddr = clearing_r ? clr_idx_r : wr_idx;
    assign wdata = clearing_r ? pixel_t'('0) : wr_pixel;
    assign we0   = clearing_r || (wr_en && !sel_r);
    assign we1   = clearing_r || (wr_en && sel_r);

    always_ff @(posedge clk) begin
        if (reset) begin
            sel_r      <= 1'b0;
            clearing_r <= 1'b1;
            clr_idx_r  <= '0;
        end else begin
            if (swap)
                sel_r <= ~sel_r;
            if (clearing_r) begin
                clr_idx_r <= clr_idx_r + 9'd1;
                if (clr_idx_r == LAST_IDX)
                    clearing_r <= 1'b0;
            end
        end
    end

    // Display side reads the bank not being drawn
    always_ff @(posedge clk) begin
        if (we0)
            bank0[waddr] <= wdata;
        if (we1)
            bank1[waddr] <= wdata;
        if (rd_idx < 9'(LINE_PIXELS))
            rd_pixel <= sel_r ? bank0[rd_idx] : bank1[rd_idx];
        else
            rd_pixel <= '0;
    end

endmodule

// ==== tb_gfx.sv ====
`timescale 1ns/1ps

module tb_gfx;
    import gfx_cfg_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_LINES  = 13;
    localparam int DONE_LIMIT = 1000;

    logic        clk;
    logic        reset;
    logic        start;
    logic [7:0]  vline;
    logic [8:0]  scrx;
    logic [7:0]  scry;
    logic [12:0] vaddr;
    logic [15:0] vdata;
    pixel_idx_t  linebuf_rdidx;
    pixel_t      linebuf_data;
    logic        busy;
    logic        line_done;

    integer seed;
    int     errors;
    int     checks;
    int     done_count;
    int     lines_expected;

    // Contents of the display-side bank: 0 blank, 1 known line
    int         prev_mode;
    string      prev_name;
    logic [7:0] prev_vline;
    logic [8:0] prev_scrx;
    logic [7:0] prev_scry;

    gfx #(.CREDITS(2)) u_dut (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .vline         (vline),
        .scrx          (scrx),
        .scry          (scry),
        .vaddr         (vaddr),
        .vdata         (vdata),
        .linebuf_rdidx (linebuf_rdidx),
        .linebuf_data  (linebuf_data),
        .busy          (busy),
        .line_done     (line_done)
    );

    tb_vram u_vram (
        .clk   (clk),
        .vaddr (vaddr),
        .vdata (vdata)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        if (reset)
            done_count <= 0;
        else if (line_done)
            done_count <= done_count + 1;
    end

    ////////////////////////////////////////////////////////////
    // Protocol checks
    ////////////////////////////////////////////////////////////
    // Fetcher needs at least 123 cycles for 41 tiles
    a_busy_after_start: assert property (@(posedge clk) disable iff (reset)
        start |=> busy [*120])
        else begin
            errors++;
            $display("busy dropped during the first 120 cycles of a line");
        end

    // Fetcher is idle by the time the last pixel is written
    a_done_when_idle: assert property (@(posedge clk) disable iff (reset)
        line_done |-> !busy)
        else begin
            errors++;
            $display("line_done pulsed while the fetcher was still busy");
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        line_done |=> !line_done)
        else begin
            errors++;
            $display("line_done stayed high for more than one cycle");
        end

    task automatic start_line(input logic [7:0] vl, input logic [8:0] sx, input logic [7:0] sy);
        vline = vl;
        scrx  = sx;
        scry  = sy;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    // Reads the display-side bank, one pixel per cycle
    task automatic read_back(input int count);
        pixel_t expected;

        for (int i = 0; i < count; i++) begin
            linebuf_rdidx = 9'(i);
            @(negedge clk);
            if (prev_mode == 1)
                expected = u_vram.ref_pixel(prev_vline, prev_scrx, prev_scry, i);
            else
                expected = '0;
            checks++;
            a_pixel: assert (linebuf_data == expected)
                else begin
                    errors++;
                    $display("[ERROR] %s pixel %0d: expected %h actual %h",
                             prev_name, i, expected, linebuf_data);
                end
        end
    endtask

    task automatic wait_done(input string name);
        int cycles;

        cycles = 0;
        while (done_count < lines_expected && cycles < DONE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (done_count < lines_expected) begin
            errors++;
            $display("line_done never arrived for line %s", name);
        end
    endtask

    task automatic remember_line(input string name, input logic [7:0] vl,
                                 input logic [8:0] sx, input logic [7:0] sy);
        prev_mode  = 1;
        prev_name  = name;
        prev_vline = vl;
        prev_scrx  = sx;
        prev_scry  = sy;
    endtask

    // Draws a line while the previous one is read back from the other bank
    task automatic render_line(input string name, input logic [7:0] vl,
                               input logic [8:0] sx, input logic [7:0] sy);
        start_line(vl, sx, sy);
        lines_expected++;
        read_back(LINE_PIXELS);
        wait_done(name);
        remember_line(name, vl, sx, sy);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    initial begin
        seed           = 32'h1b5c_bdb4;
        errors         = 0;
        checks         = 0;
        lines_expected = 0;
        prev_mode      = 0;
        prev_name      = "reset";
        reset          = 1'b1;
        start          = 1'b0;
        vline          = '0;
        scrx           = '0;
        scry           = '0;
        linebuf_rdidx  = '0;

        repeat (10) @(negedge clk);
        reset = 1'b0;
        // Line buffer clear pass
        repeat (LINE_PIXELS + 2) @(negedge clk);
        a_reset_idle: assert (!busy && !line_done)
            else begin
                errors++;
                $display("busy or line_done high after reset");
            end
        read_back(LINE_PIXELS);

        render_line("basic_a", 8'd16, 9'd0, 8'd0);
        render_line("basic_b", 8'd100, 9'd0, 8'd0);
        render_line("flip_a", 8'd43, 9'd0, 8'd0);
        render_line("flip_b", 8'd221, 9'd0, 8'd0);
        // Column 61 plus 41 tiles crosses the wrap at 64
        render_line("scroll_wrap", 8'd70, 9'h1ed, 8'd5);
        for (int n = 0; n < 5; n++) begin
            render_line("scroll_rand", 8'($random(seed)), 9'($random(seed)),
                        8'($random(seed)));
        end

        // Abandon a line partway through, then draw a new one in its place
        start_line(8'd120, 9'd13, 8'd7);
        // Last random line stays readable only until the restart swaps banks
        read_back(100);
        a_busy_mid_line: assert (busy)
            else begin
                errors++;
                $display("fetcher was not busy before the restart");
            end
        start_line(8'd33, 9'h0a3, 8'd250);
        lines_expected++;
        wait_done("restart");
        remember_line("restart", 8'd33, 9'h0a3, 8'd250);

        render_line("flush", 8'd0, 9'd0, 8'd0);

        repeat (20) @(negedge clk);
        a_done_count: assert (done_count == lines_expected)
            else begin
                errors++;
                $display("[ERROR] line_done count: expected %0d actual %0d",
                         lines_expected, done_count);
            end

        $display("Pixel checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    // Watchdog
    initial begin
        #((NUM_LINES * 420 + 2000) * CLK_PERIOD);
        $display("Watchdog timeout, simulation did not finish in time");
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== tb_vram.sv ====
`timescale 1ns/1ps

module tb_vram (
    input  logic        clk,
    input  logic [12:0] vaddr,
    output logic [15:0] vdata
);
    import gfx_cfg_pkg::*;

    logic [15:0] mem [8192];
    integer      seed;

    // Random map and pattern words, so flip bits show up on many entries
    initial begin
        seed  = 32'h1b5c_bdb4;
        vdata = '0;
        for (int a = 0; a < 8192; a++) begin
            mem[a] = 16'($random(seed));
        end
    end

    // One-cycle read latency
    always @(posedge clk) begin
        vdata <= mem[vaddr];
    end

    ////////////////////////////////////////////////////////////
    // Expected pixel at screen position pos
    ////////////////////////////////////////////////////////////
    // Map word: tile 8:0, hflip 9, vflip 10, palette 13:12
    function automatic logic [5:0] ref_pixel(input logic [7:0] vline, input logic [8:0] scrx,
                                             input logic [7:0] scry, input int pos);
        logic [7:0]  tline;
        logic [5:0]  col;
        logic [2:0]  row;
        logic [15:0] entry;
        logic [15:0] pat;
        int          q;

        tline = vline - 8'(TOP_BORDER) + scry;
        // Map column wraps at 64
        col   = 6'(int'(scrx[8:3]) + (pos + int'(scrx[2:0])) / 8);
        entry = mem[{2'b00, tline[7:3], col}];
        row   = entry[10] ? ~tline[2:0] : tline[2:0];
        q     = (pos + int'(scrx[2:0])) % 8;
        if (entry[9])
            q = 7 - q;
        // Leftmost pixel of each half row sits in the top nibble
        pat = mem[{entry[8:0], row, q[2]}];
        return {entry[13:12], pat[(3 - q % 4) * 4 +: 4]};
    endfunction

endmodule

// ==== tile_fetcher.sv ====
`timescale 1ns/1ps

module tile_fetcher #(
    parameter int CREDITS = 2
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  logic  [7:0] vline,
    input  logic  [8:3] scrx,
    input  logic  [7:0] scry,
    output logic [12:0] vaddr,
    input  logic [15:0] vdata,
    tile_job_if.source  jobs,
    output logic        busy
);
    import gfx_cfg_pkg::*;
    import vram_fmt_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MAP,
        ST_PAT_L,
        ST_PAT_H
    } state_t;

    localparam int         CNT_W     = $clog2(CREDITS + 1);
    localparam logic [5:0] LAST_SLOT = 6'(TILES_PER_LINE - 1);

    state_t           state_r;
    logic [5:0]       slot_r;
    logic [CNT_W-1:0] credit_r;

    logic [7:0]    tline_r;
    logic [5:0]    col_r;
    map_entry_t    map_r;
    pattern_word_t pat_lo_r;

    vram_word_t word;
    logic [7:0] tline_start;
    logic       issue;
    logic       last;

    function automatic logic [12:0] map_addr(input logic [4:0] row, input logic [5:0] col);
        return {2'b00, row, col};
    endfunction

    // Row within the tile counts upward unless the tile is flipped vertically
    function automatic logic [12:0] pattern_addr(input map_entry_t entry,
                                                 input logic [2:0] line,
                                                 input logic half);
        logic [2:0] row;
        row = entry.vflip ? ~line : line;
        return {entry.tile_idx, row, half};
    endfunction

    assign word        = vdata;
    assign tline_start = vline - 8'(TOP_BORDER) + scry;
    assign issue       = (state_r == ST_PAT_H) && (credit_r != '0) && !start;
    assign last        = (slot_r == LAST_SLOT);
    assign busy        = (state_r != ST_IDLE);

    ////////////////////////////////////////////////////////////
    // Address for the read whose data arrives next cycle
    ////////////////////////////////////////////////////////////
    always_comb begin
        vaddr = '0;
        if (start) begin
            vaddr = map_addr(tline_start[7:3], scrx);
        end else begin
            case (state_r)
                ST_MAP:   vaddr = pattern_addr(word.map, tline_r[2:0], 1'b0);
                ST_PAT_L: vaddr = pattern_addr(map_r, tline_r[2:0], 1'b1);
                ST_PAT_H: begin
                    if (issue && !last)
                        vaddr = map_addr(tline_r[7:3], col_r + 6'd1);
                    else
                        // Keep rereading the high word while out of credit
                        vaddr = pattern_addr(map_r, tline_r[2:0], 1'b1);
                end
                default:  vaddr = '0;
            endcase
        end
    end

    // Control state
    always_ff @(posedge clk) begin
        if (reset) begin
            state_r  <= ST_IDLE;
            slot_r   <= '0;
            credit_r <= CNT_W'(CREDITS);
        end else if (start) begin
            state_r  <= ST_MAP;
            slot_r   <= '0;
            credit_r <= CNT_W'(CREDITS);
        end else begin
            case ({issue, jobs.credit_return})
                2'b10:   credit_r <= credit_r - 1'b1;
                2'b01:   credit_r <= credit_r + 1'b1;
                default: credit_r <= credit_r;
            endcase

            case (state_r)
                ST_MAP:   state_r <= ST_PAT_L;
                ST_PAT_L: state_r <= ST_PAT_H;
                ST_PAT_H: begin
                    if (issue) begin
                        state_r <= last ? ST_IDLE : ST_MAP;
                        slot_r  <= slot_r + 6'd1;
                    end
                end
                default:  state_r <= ST_IDLE;
            endcase
        end
    end

    // Line parameters and captured VRAM words
    always_ff @(posedge clk) begin
        if (start) begin
            tline_r <= tline_start;
            col_r   <= scrx;
        end else if (issue) begin
            col_r   <= col_r + 6'd1;
        end
        if (state_r == ST_MAP)
            map_r <= word.map;
        if (state_r == ST_PAT_L)
            pat_lo_r <= word.pattern;
    end

    assign jobs.job_valid = issue;
    assign jobs.job = '{row:     {pat_lo_r, word.pattern},
                        palette: map_r.palette,
                        hflip:   map_r.hflip,
                        slot:    slot_r};

    a_credit_max: assert property (@(posedge clk) disable iff (reset)
        credit_r <= CREDITS)
        else $error("tile_fetcher: credit count %0d above %0d", credit_r, CREDITS);

endmodule

// ==== tile_job_if.sv ====
`timescale 1ns/1ps

interface tile_job_if #(
    parameter int CREDITS = 2
) (
    input logic clk,
    input logic reset
);
    import vram_fmt_pkg::*;

    logic      job_valid;
    tile_job_t job;
    logic      credit_return;

    // Queue depth and pointer logic are built for 1 to 4 entries
    if (CREDITS < 1 || CREDITS > 4) begin : g_bad_credits
        $error("tile_job_if: CREDITS must be between 1 and 4");
    end

    modport source (
        input  clk, reset, credit_return,
        output job_valid, job
    );

    modport sink (
        input  clk, reset, job_valid, job,
        output credit_return
    );

    // A tile costs the fetcher at least three VRAM reads
    a_job_spacing: assert property (@(posedge clk) disable iff (reset)
        job_valid |=> !job_valid)
        else $error("tile_job_if: job_valid high on two adjacent cycles");

    // Renderer draws for several cycles after each pop
    a_credit_spacing: assert property (@(posedge clk) disable iff (reset)
        credit_return |=> !credit_return)
        else $error("tile_job_if: credit_return high on two adjacent cycles");

endinterface

// ==== tile_renderer.sv ====
`timescale 1ns/1ps

module tile_renderer #(
    parameter int CREDITS = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic             [2:0] scrx_fine,
    tile_job_if.sink               jobs,
    output gfx_cfg_pkg::pixel_idx_t wr_idx,
    output gfx_cfg_pkg::pixel_t    wr_pixel,
    output logic                   wr_en,
    output logic                   line_done
);
    import gfx_cfg_pkg::*;
    import vram_fmt_pkg::*;

    localparam int         PTR_W     = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int         CNT_W     = $clog2(CREDITS + 1);
    localparam logic [5:0] LAST_SLOT = 6'(TILES_PER_LINE - 1);

    tile_job_t        queue [CREDITS];
    logic [PTR_W-1:0] wr_ptr_r;
    logic [PTR_W-1:0] rd_ptr_r;
    logic [CNT_W-1:0] count_r;

    logic        drawing_r;
    logic [2:0]  pix_r;
    logic [31:0] shift_r;
    logic [1:0]  pal_r;
    logic        hflip_r;
    logic [5:0]  slot_r;
    logic [2:0]  fine_r;

    tile_job_t   head;
    logic        push;
    logic        pop;
    logic        emit;
    logic [31:0] cur_row;
    logic        cur_hflip;
    logic [5:0]  cur_slot;
    logic [2:0]  cur_pix;
    logic [9:0]  pos;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(CREDITS - 1)) ? '0 : ptr + 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////
    // Job queue
    ////////////////////////////////////////////////////////////
    assign head = queue[rd_ptr_r];
    assign push = jobs.job_valid && !start;
    // Pixel 0 of a job is drawn straight from the queue head
    assign pop  = !start && !drawing_r && (count_r != '0);

    assign jobs.credit_return = pop;

    always_ff @(posedge clk) begin
        if (reset || start) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (push)
                wr_ptr_r <= next_ptr(wr_ptr_r);
            if (pop)
                rd_ptr_r <= next_ptr(rd_ptr_r);
            count_r <= count_r + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            queue[wr_ptr_r] <= jobs.job;
    end

    ////////////////////////////////////////////////////////////
    // Pixel shifter
    ////////////////////////////////////////////////////////////
    assign emit      = !start && (pop || drawing_r);
    assign cur_row   = pop ? head.row   : shift_r;
    assign cur_hflip = pop ? head.hflip : hflip_r;
    assign cur_slot  = pop ? head.slot  : slot_r;
    assign cur_pix   = pop ? 3'd0       : pix_r;

    // Screen position goes negative for the leading pixels of tile 0
    assign pos = {1'b0, cur_slot, cur_pix} - {7'b0, fine_r};

    assign wr_en = emit && !pos[9] && (pos[8:0] < 9'(LINE_PIXELS));
    assign wr_idx = pos[8:0];
    assign wr_pixel = '{palette: pop ? head.palette : pal_r,
                        color:   cur_hflip ? cur_row[3:0] : cur_row[31:28]};

    always_ff @(posedge clk) begin
        if (reset || start) begin
            drawing_r <= 1'b0;
            pix_r     <= '0;
            line_done <= 1'b0;
        end else begin
            if (emit) begin
                pix_r     <= cur_pix + 3'd1;
                drawing_r <= (cur_pix != 3'd7);
            end
            line_done <= emit && (cur_slot == LAST_SLOT) && (cur_pix == 3'd7);
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            fine_r <= scrx_fine;
        if (emit)
            shift_r <= cur_hflip ? (cur_row >> 4) : (cur_row << 4);
        if (pop) begin
            pal_r   <= head.palette;
            hflip_r <= head.hflip;
            slot_r  <= head.slot;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        jobs.job_valid |-> count_r < CREDITS)
        else $error("tile_renderer: job pushed into a full queue");

endmodule

// ==== vram_fmt_pkg.sv ====
package vram_fmt_pkg;

    ////////////////////////////////////////////////////////////
    // VRAM word formats
    ////////////////////////////////////////////////////////////

    // Tile map entry
    typedef struct packed {
        logic       unused_hi;
        logic       prio;
        logic [1:0] palette;
        logic       unused_lo;
        logic       vflip;
        logic       hflip;
        logic [8:0] tile_idx;
    } map_entry_t;

    // Four 4-bit colour indices, element 3 is the leftmost pixel
    typedef logic [3:0][3:0] pattern_word_t;

    // One VRAM read is either a map entry or half a pattern row
    typedef union packed {
        map_entry_t    map;
        pattern_word_t pattern;
    } vram_word_t;

    ////////////////////////////////////////////////////////////
    // Tile job passed from fetcher to renderer
    ////////////////////////////////////////////////////////////

    // Row holds the low pattern word in bits 31:16 and the high word in 15:0
    // so pixel 0 sits in the top nibble and pixel 7 in the bottom one
    typedef struct packed {
        logic [31:0] row;
        logic [1:0]  palette;
        logic        hflip;
        logic [5:0]  slot;
    } tile_job_t;

endpackage
